//--- hdl/npc_core.sv
`timescale 1ns/1ps

module npc_core #(
  parameter npc_pkg::addr_t RESET_PC = '0
) (
  input  logic              clk,
  input  logic              rst,
  output logic              mem_valid_o,
  output npc_pkg::mem_req_t mem_req_o,
  input  logic              mem_ready_i,
  input  npc_pkg::dword_t   mem_rdata_i,
  output logic              halt_o
);

  logic [npc_pkg::NUM_STAGES-1:0] stage_en;
  logic                           fetch_start;
  logic                           data_start;
  logic                           mem_done;
  npc_pkg::dword_t                mem_rdata;
  npc_pkg::mem_req_t              fetch_req;
  npc_pkg::mem_req_t              data_req;
  logic                           needs_mem;
  logic                           is_ebreak;

  npc_sequencer u_sequencer (
    .clk           (clk),
    .rst           (rst),
    .needs_mem_i   (needs_mem),
    .is_ebreak_i   (is_ebreak),
    .mem_done_i    (mem_done),
    .stage_en_o    (stage_en),
    .fetch_start_o (fetch_start),
    .data_start_o  (data_start),
    .halt_o        (halt_o)
  );

  npc_datapath #(
    .RESET_PC (RESET_PC)
  ) u_datapath (
    .clk         (clk),
    .rst         (rst),
    .stage_en_i  (stage_en),
    .mem_done_i  (mem_done),
    .mem_rdata_i (mem_rdata),
    .fetch_req_o (fetch_req),
    .data_req_o  (data_req),
    .needs_mem_o (needs_mem),
    .is_ebreak_o (is_ebreak)
  );

  // fetch and data never start together, one port is enough
  npc_mem_port u_mem_port (
    .clk           (clk),
    .rst           (rst),
    .fetch_start_i (fetch_start),
    .data_start_i  (data_start),
    .fetch_req_i   (fetch_req),
    .data_req_i    (data_req),
    .mem_ready_i   (mem_ready_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_valid_o   (mem_valid_o),
    .mem_req_o     (mem_req_o),
    .mem_done_o    (mem_done),
    .mem_rdata_o   (mem_rdata)
  );

endmodule

//--- hdl/npc_datapath.sv
`timescale 1ns/1ps

module npc_datapath #(
  parameter npc_pkg::addr_t RESET_PC = '0
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [npc_pkg::NUM_STAGES-1:0] stage_en_i,
  input  logic                           mem_done_i,
  input  npc_pkg::dword_t                mem_rdata_i,
  output npc_pkg::mem_req_t              fetch_req_o,
  output npc_pkg::mem_req_t              data_req_o,
  output logic                           needs_mem_o,
  output logic                           is_ebreak_o
);

  localparam int XL = npc_pkg::XLEN;

  typedef struct packed {
    npc_pkg::ctrl_t    ctrl;
    npc_pkg::dword_t   rs1_data;
    npc_pkg::dword_t   rs2_data;
    npc_pkg::dword_t   imm;
    npc_pkg::reg_idx_t rd;
  } de_reg_t;

  typedef struct packed {
    npc_pkg::ctrl_t    ctrl;
    npc_pkg::dword_t   sum;
    npc_pkg::dword_t   store_data;
    npc_pkg::dword_t   imm;
    npc_pkg::reg_idx_t rd;
  } ex_reg_t;

  typedef struct packed {
    npc_pkg::ctrl_t    ctrl;
    npc_pkg::dword_t   alu;
    npc_pkg::dword_t   load_data;
    npc_pkg::dword_t   imm;
    npc_pkg::reg_idx_t rd;
  } mem_reg_t;

  npc_pkg::addr_t    pc_q;
  npc_pkg::inst_u    ir_q;
  npc_pkg::ctrl_t    dec_ctrl;
  npc_pkg::dword_t   dec_imm;
  npc_pkg::reg_idx_t rs1;
  npc_pkg::reg_idx_t rs2;
  npc_pkg::reg_idx_t rd;
  npc_pkg::dword_t   rs1_data;
  npc_pkg::dword_t   rs2_data;
  de_reg_t           de_q;
  ex_reg_t           ex_q;
  mem_reg_t          mem_q;
  npc_pkg::dword_t   op_b;
  logic [2:0]        lane;
  logic [7:0]        size_mask;
  npc_pkg::dword_t   wb_raw;
  npc_pkg::dword_t   wb_data;

  // pc only steps by four, at writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else if (stage_en_i[npc_pkg::STG_WB]) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // pc bit 2 picks the word inside the fetched doubleword
  always_ff @(posedge clk) begin
    if (stage_en_i[npc_pkg::STG_IF] && mem_done_i) begin
      ir_q <= pc_q[2] ? mem_rdata_i[63:32] : mem_rdata_i[31:0];
    end
  end

  npc_decoder u_decoder (
    .inst_i (ir_q),
    .ctrl_o (dec_ctrl),
    .imm_o  (dec_imm),
    .rs1_o  (rs1),
    .rs2_o  (rs2),
    .rd_o   (rd)
  );

  npc_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rd_i       (mem_q.rd),
    .wen_i      (stage_en_i[npc_pkg::STG_WB] && mem_q.ctrl.rd_wen),
    .wdata_i    (wb_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  // adder operand b: register or immediate
  assign op_b = de_q.ctrl.alu_imm ? de_q.imm : de_q.rs2_data;
  // byte offset inside the doubleword
  assign lane = ex_q.sum[2:0];

  always_ff @(posedge clk) begin
    if (stage_en_i[npc_pkg::STG_ID]) begin
      de_q.ctrl     <= dec_ctrl;
      de_q.rs1_data <= rs1_data;
      de_q.rs2_data <= rs2_data;
      de_q.imm      <= dec_imm;
      de_q.rd       <= rd;
    end
    if (stage_en_i[npc_pkg::STG_EX]) begin
      ex_q.ctrl       <= de_q.ctrl;
      ex_q.sum        <= de_q.rs1_data + op_b;
      ex_q.store_data <= de_q.rs2_data;
      ex_q.imm        <= de_q.imm;
      ex_q.rd         <= de_q.rd;
    end
    // last update lands in the mem_done cycle of a load
    if (stage_en_i[npc_pkg::STG_MEM]) begin
      mem_q.ctrl      <= ex_q.ctrl;
      mem_q.alu       <= ex_q.sum;
      mem_q.load_data <= mem_rdata_i >> {lane, 3'b000};
      mem_q.imm       <= ex_q.imm;
      mem_q.rd        <= ex_q.rd;
    end
  end

  always_comb begin
    case (ex_q.ctrl.mem_size)
      2'd0:    size_mask = 8'h01;
      2'd1:    size_mask = 8'h03;
      2'd2:    size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  assign fetch_req_o.addr  = pc_q;
  assign fetch_req_o.wdata = '0;
  assign fetch_req_o.wmask = '0;
  assign fetch_req_o.write = 1'b0;

  // store data moved into its byte lanes
  assign data_req_o.addr  = ex_q.sum[npc_pkg::ADDR_W-1:0];
  assign data_req_o.wdata = ex_q.store_data << {lane, 3'b000};
  assign data_req_o.wmask = ex_q.ctrl.mem_write ? (size_mask << lane) : 8'h00;
  assign data_req_o.write = ex_q.ctrl.mem_write;

  assign needs_mem_o = ex_q.ctrl.mem_read || ex_q.ctrl.mem_write;
  assign is_ebreak_o = ex_q.ctrl.ebreak;

  // writeback source, then extension
  always_comb begin
    case (mem_q.ctrl.rd_src)
      npc_pkg::SRC_MEM: wb_raw = mem_q.load_data;
      npc_pkg::SRC_IMM: wb_raw = mem_q.imm;
      default:          wb_raw = mem_q.alu;
    endcase
    case (mem_q.ctrl.rd_ext)
      npc_pkg::EXT_B:  wb_data = {{(XL-8){wb_raw[7]}}, wb_raw[7:0]};
      npc_pkg::EXT_BU: wb_data = {{(XL-8){1'b0}}, wb_raw[7:0]};
      npc_pkg::EXT_H:  wb_data = {{(XL-16){wb_raw[15]}}, wb_raw[15:0]};
      npc_pkg::EXT_HU: wb_data = {{(XL-16){1'b0}}, wb_raw[15:0]};
      npc_pkg::EXT_W:  wb_data = {{(XL-32){wb_raw[31]}}, wb_raw[31:0]};
      npc_pkg::EXT_WU: wb_data = {{(XL-32){1'b0}}, wb_raw[31:0]};
      default:         wb_data = wb_raw;
    endcase
  end

endmodule

//--- hdl/npc_decoder.sv
`timescale 1ns/1ps

module npc_decoder (
  input  npc_pkg::inst_u    inst_i,
  output npc_pkg::ctrl_t    ctrl_o,
  output npc_pkg::dword_t   imm_o,
  output npc_pkg::reg_idx_t rs1_o,
  output npc_pkg::reg_idx_t rs2_o,
  output npc_pkg::reg_idx_t rd_o
);

  logic [31:0] raw;
  logic [2:0]  funct3;

  assign raw    = inst_i;
  assign funct3 = inst_i.i.funct3;

  // register fields sit at the same place in both layouts
  assign rs1_o = inst_i.i.rs1;
  assign rs2_o = inst_i.s.rs2;
  assign rd_o  = inst_i.i.rd;

  always_comb begin
    ctrl_o        = '0;
    ctrl_o.rd_src = npc_pkg::SRC_ALU;
    ctrl_o.rd_ext = npc_pkg::EXT_D;
    imm_o         = '0;
    case (inst_i.i.opcode)
      npc_pkg::OPC_LOAD: begin
        imm_o = {{(npc_pkg::XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
        // funct3 111 has no load, falls through as a no-op
        if (funct3 != 3'b111) begin
          ctrl_o.rd_src   = npc_pkg::SRC_MEM;
          ctrl_o.rd_wen   = 1'b1;
          ctrl_o.mem_read = 1'b1;
          ctrl_o.alu_imm  = 1'b1;
          ctrl_o.mem_size = funct3[1:0];
        end
        case (funct3)
          3'b000:  ctrl_o.rd_ext = npc_pkg::EXT_B;
          3'b001:  ctrl_o.rd_ext = npc_pkg::EXT_H;
          3'b010:  ctrl_o.rd_ext = npc_pkg::EXT_W;
          3'b100:  ctrl_o.rd_ext = npc_pkg::EXT_BU;
          3'b101:  ctrl_o.rd_ext = npc_pkg::EXT_HU;
          3'b110:  ctrl_o.rd_ext = npc_pkg::EXT_WU;
          default: ctrl_o.rd_ext = npc_pkg::EXT_D;
        endcase
      end
      npc_pkg::OPC_STORE: begin
        imm_o = {{(npc_pkg::XLEN-12){inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
        // sb, sh, sw, sd only
        if (!funct3[2]) begin
          ctrl_o.mem_write = 1'b1;
          ctrl_o.alu_imm   = 1'b1;
          ctrl_o.mem_size  = funct3[1:0];
        end
      end
      npc_pkg::OPC_OP_IMM: begin
        imm_o = {{(npc_pkg::XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
        // addi
        if (funct3 == 3'b000) begin
          ctrl_o.rd_wen  = 1'b1;
          ctrl_o.alu_imm = 1'b1;
        end
      end
      npc_pkg::OPC_OP: begin
        // add, funct7 shares the s-type upper imm slot
        if (funct3 == 3'b000 && inst_i.s.imm_hi == 7'd0) begin
          ctrl_o.rd_wen = 1'b1;
        end
      end
      npc_pkg::OPC_LUI: begin
        imm_o         = {{(npc_pkg::XLEN-32){raw[31]}}, raw[31:12], 12'h000};
        ctrl_o.rd_src = npc_pkg::SRC_IMM;
        ctrl_o.rd_wen = 1'b1;
      end
      npc_pkg::OPC_SYSTEM: begin
        // ebreak: imm of 1, every other field zero
        ctrl_o.ebreak = (raw[31:7] == 25'h0002000);
      end
      default: ctrl_o = '0;
    endcase
  end

endmodule

//--- hdl/npc_mem_port.sv
`timescale 1ns/1ps

module npc_mem_port (
  input  logic              clk,
  input  logic              rst,
  input  logic              fetch_start_i,
  input  logic              data_start_i,
  input  npc_pkg::mem_req_t fetch_req_i,
  input  npc_pkg::mem_req_t data_req_i,
  input  logic              mem_ready_i,
  input  npc_pkg::dword_t   mem_rdata_i,
  output logic              mem_valid_o,
  output npc_pkg::mem_req_t mem_req_o,
  output logic              mem_done_o,
  output npc_pkg::dword_t   mem_rdata_o
);

  logic              valid_q;
  logic              done_q;
  npc_pkg::mem_req_t req_q;
  npc_pkg::dword_t   rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      // access completes in the first ready cycle
      done_q <= valid_q && mem_ready_i;
      if (fetch_start_i || data_start_i) begin
        valid_q <= 1'b1;
      end else if (mem_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  // request held stable while valid, whatever ready does
  always_ff @(posedge clk) begin
    if (fetch_start_i) begin
      req_q <= fetch_req_i;
    end else if (data_start_i) begin
      req_q <= data_req_i;
    end
    if (valid_q && mem_ready_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign mem_valid_o = valid_q;
  assign mem_req_o   = req_q;
  assign mem_done_o  = done_q;
  assign mem_rdata_o = rdata_q;

endmodule

//--- hdl/npc_pkg.sv
package npc_pkg;

  // datapath and bus widths
  localparam int XLEN   = 64;
  localparam int ADDR_W = 32;

  // one-hot stage enables, fetch first
  localparam int NUM_STAGES = 5;
  localparam int STG_IF     = 0;
  localparam int STG_ID     = 1;
  localparam int STG_EX     = 2;
  localparam int STG_MEM    = 3;
  localparam int STG_WB     = 4;

  typedef logic [XLEN-1:0]   dword_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [4:0]        reg_idx_t;

  // where the writeback value comes from
  typedef enum logic [1:0] {
    SRC_ALU = 2'd0,
    SRC_MEM = 2'd1,
    SRC_IMM = 2'd2
  } rd_src_e;

  // sign or zero extension applied before the register write
  typedef enum logic [2:0] {
    EXT_B  = 3'd0,
    EXT_BU = 3'd1,
    EXT_H  = 3'd2,
    EXT_HU = 3'd3,
    EXT_W  = 3'd4,
    EXT_WU = 3'd5,
    EXT_D  = 3'd6
  } rd_ext_e;

  typedef struct packed {
    rd_src_e    rd_src;
    rd_ext_e    rd_ext;
    logic       rd_wen;
    logic       mem_read;
    logic       mem_write;
    logic       alu_imm;
    logic       ebreak;
    // log2 of access size in bytes
    logic [1:0] mem_size;
  } ctrl_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } inst_s_t;

  // same instruction word, i-type or s-type layout
  typedef union packed {
    inst_i_t i;
    inst_s_t s;
  } inst_u;

  typedef struct packed {
    addr_t      addr;
    dword_t     wdata;
    // one bit per byte lane
    logic [7:0] wmask;
    logic       write;
  } mem_req_t;

  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

//--- hdl/npc_regfile.sv
`timescale 1ns/1ps

module npc_regfile (
  input  logic              clk,
  input  logic              rst,
  input  npc_pkg::reg_idx_t rs1_i,
  input  npc_pkg::reg_idx_t rs2_i,
  input  npc_pkg::reg_idx_t rd_i,
  input  logic              wen_i,
  input  npc_pkg::dword_t   wdata_i,
  output npc_pkg::dword_t   rs1_data_o,
  output npc_pkg::dword_t   rs2_data_o
);

  npc_pkg::dword_t regs_q [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wen_i && (rd_i != 5'd0)) begin
      // x0 never written, so it reads back zero
      regs_q[rd_i] <= wdata_i;
    end
  end

  // asynchronous reads
  assign rs1_data_o = regs_q[rs1_i];
  assign rs2_data_o = regs_q[rs2_i];

endmodule

//--- hdl/npc_sequencer.sv
`timescale 1ns/1ps

module npc_sequencer (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           needs_mem_i,
  input  logic                           is_ebreak_i,
  input  logic                           mem_done_i,
  output logic [npc_pkg::NUM_STAGES-1:0] stage_en_o,
  output logic                           fetch_start_o,
  output logic                           data_start_o,
  output logic                           halt_o
);

  typedef enum logic [2:0] {
    S_FETCH      = 3'd0,
    S_FETCH_WAIT = 3'd1,
    S_DECODE     = 3'd2,
    S_EXEC       = 3'd3,
    S_MEM        = 3'd4,
    S_MEM_WAIT   = 3'd5,
    S_WB         = 3'd6,
    S_HALT       = 3'd7
  } state_e;

  state_e state_q;
  state_e state_d;

  // one instruction at a time, stepped through every stage
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_FETCH:      state_d = S_FETCH_WAIT;
      S_FETCH_WAIT: state_d = mem_done_i ? S_DECODE : S_FETCH_WAIT;
      S_DECODE:     state_d = S_EXEC;
      S_EXEC:       state_d = S_MEM;
      // no load or store: memory stage is a single cycle
      S_MEM:        state_d = needs_mem_i ? S_MEM_WAIT : S_WB;
      S_MEM_WAIT:   state_d = mem_done_i ? S_WB : S_MEM_WAIT;
      // ebreak parks the core until reset
      S_WB:         state_d = is_ebreak_i ? S_HALT : S_FETCH;
      S_HALT:       state_d = S_HALT;
      default:      state_d = S_FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  // stage enables stay high across the memory wait states
  always_comb begin
    stage_en_o = '0;
    case (state_q)
      S_FETCH, S_FETCH_WAIT: stage_en_o[npc_pkg::STG_IF] = 1'b1;
      S_DECODE:              stage_en_o[npc_pkg::STG_ID] = 1'b1;
      S_EXEC:                stage_en_o[npc_pkg::STG_EX] = 1'b1;
      S_MEM, S_MEM_WAIT:     stage_en_o[npc_pkg::STG_MEM] = 1'b1;
      S_WB:                  stage_en_o[npc_pkg::STG_WB] = 1'b1;
      default:               stage_en_o = '0;
    endcase
  end

  // start strobes fire on the way into a wait state
  assign fetch_start_o = (state_q == S_FETCH);
  assign data_start_o  = (state_q == S_MEM) && needs_mem_i;
  assign halt_o        = (state_q == S_HALT);

endmodule

//--- npc_core.f
hdl/npc_pkg.sv
hdl/npc_sequencer.sv
hdl/npc_decoder.sv
hdl/npc_regfile.sv
hdl/npc_datapath.sv
hdl/npc_mem_port.sv
hdl/npc_core.sv
tb/npc_tb_mem.sv
tb/npc_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module npc_core_tb \
  -f npc_core.f -o npc_core_sim

out=$(./obj_dir/npc_core_sim)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1

//--- tb/npc_core_tb.sv
`timescale 1ns/1ps

module npc_core_tb;

  localparam npc_pkg::addr_t RESET_PC  = 32'h1000;
  localparam npc_pkg::addr_t DATA_BASE = 32'h2000;
  localparam int             DUMP_OFF  = 256;
  localparam int             MEM_DW    = 2048;
  localparam int             DATA_IDX  = 1024;
  localparam int             DUMP_IDX  = DATA_IDX + DUMP_OFF / 8;
  // random data area plus the register dump
  localparam int             CHECK_DW  = 40;
  localparam int             N_RAND    = 200;
  // base lui, random body, seven dump stores, ebreak
  localparam int             N_INSTS   = N_RAND + 9;
  localparam int             TIMEOUT   = 20 * N_INSTS + 100;
  localparam int unsigned    SEED      = 32'hc5ad_afee;

  localparam int K_ADD    = 0;
  localparam int K_ADDI   = 1;
  localparam int K_LUI    = 2;
  localparam int K_LOAD   = 3;
  localparam int K_STORE  = 4;
  localparam int K_EBREAK = 5;

  localparam int REQ_FETCH = 0;
  localparam int REQ_LOAD  = 1;
  localparam int REQ_STORE = 2;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  logic              mem_valid;
  npc_pkg::mem_req_t mem_req;
  logic              mem_ready;
  npc_pkg::dword_t   mem_rdata;
  logic              halt;
  logic              cmpl;
  npc_pkg::mem_req_t cmpl_req;

  // one entry per generated instruction
  int                kind_a [N_INSTS];
  int                rd_a [N_INSTS];
  int                rs1_a [N_INSTS];
  int                rs2_a [N_INSTS];
  int                f3_a [N_INSTS];
  logic [31:0]       imm_a [N_INSTS];
  logic [31:0]       word_a [N_INSTS];
  int                n_insts = 0;

  npc_pkg::dword_t   model_regs [8];
  npc_pkg::dword_t   model_mem [MEM_DW];
  int                exp_kind [$];
  npc_pkg::mem_req_t exp_req [$];

  int                addr_errs  = 0;
  int                req_errs   = 0;
  int                data_errs  = 0;
  int                proto_errs = 0;
  int                cycle_cnt  = 0;
  int                low_cycles = 0;
  int                period_done = 0;
  logic              halt_seen  = 1'b0;
  logic              prev_valid = 1'b0;
  logic              prev_ready = 1'b0;
  npc_pkg::mem_req_t prev_req   = '0;

  npc_core #(
    .RESET_PC (RESET_PC)
  ) DUT (
    .clk         (clk),
    .rst         (rst),
    .mem_valid_o (mem_valid),
    .mem_req_o   (mem_req),
    .mem_ready_i (mem_ready),
    .mem_rdata_i (mem_rdata),
    .halt_o      (halt)
  );

  npc_tb_mem #(
    .MEM_DW (MEM_DW)
  ) u_mem (
    .clk         (clk),
    .rst         (rst),
    .mem_valid_i (mem_valid),
    .mem_req_i   (mem_req),
    .mem_ready_o (mem_ready),
    .mem_rdata_o (mem_rdata),
    .cmpl_o      (cmpl),
    .cmpl_req_o  (cmpl_req)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  function automatic npc_pkg::dword_t byte_lanes(input logic [7:0] m);
    npc_pkg::dword_t l;
    l = '0;
    for (int b = 0; b < 8; b++) begin
      l[8*b +: 8] = {8{m[b]}};
    end
    return l;
  endfunction

  // fill depends on every address bit
  function automatic npc_pkg::dword_t fill_word(input npc_pkg::addr_t a);
    return {a ^ 32'h9e37_79b9, ~a ^ 32'h0f0f_3c3c};
  endfunction

  task automatic check_addr(input string name, input npc_pkg::addr_t act,
                            input npc_pkg::addr_t exp);
    if (act !== exp) begin
      $display("error %s: got %h expected %h", name, act, exp);
      addr_errs++;
    end
  endtask

  task automatic check_req(input string name, input npc_pkg::mem_req_t act,
                           input npc_pkg::mem_req_t exp);
    if (act !== exp) begin
      $display("error %s: got addr %h wdata %h wmask %h write %h", name,
               act.addr, act.wdata, act.wmask, act.write);
      $display("  expected addr %h wdata %h wmask %h write %h",
               exp.addr, exp.wdata, exp.wmask, exp.write);
      req_errs++;
    end
  endtask

  task automatic check_dword(input string name, input npc_pkg::dword_t act,
                             input npc_pkg::dword_t exp);
    if (act !== exp) begin
      $display("error %s: got %h expected %h", name, act, exp);
      data_errs++;
    end
  endtask

  // encode from the RV64I formats
  task automatic add_inst(input int k, input int rd, input int rs1, input int rs2,
                          input int f3, input logic [31:0] imm);
    logic [31:0] w;
    case (k)
      K_ADD:   w = {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], npc_pkg::OPC_OP};
      K_ADDI:  w = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], npc_pkg::OPC_OP_IMM};
      K_LUI:   w = {imm[19:0], rd[4:0], npc_pkg::OPC_LUI};
      K_LOAD:  w = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], npc_pkg::OPC_LOAD};
      K_STORE: w = {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], npc_pkg::OPC_STORE};
      default: w = 32'h0010_0073;
    endcase
    kind_a[n_insts] = k;
    rd_a[n_insts]   = rd;
    rs1_a[n_insts]  = rs1;
    rs2_a[n_insts]  = rs2;
    f3_a[n_insts]   = f3;
    imm_a[n_insts]  = imm;
    word_a[n_insts] = w;
    n_insts++;
  endtask

  // x7 holds the data base and random results go to x1..x6
  task automatic gen_program;
    int r;
    int rd;
    int rs1;
    int rs2;
    int f3;
    int off;
    add_inst(K_LUI, 7, 0, 0, 0, DATA_BASE >> 12);
    for (int i = 0; i < N_RAND; i++) begin
      r   = $urandom % 100;
      rd  = 1 + $urandom % 6;
      rs1 = 1 + $urandom % 7;
      rs2 = 1 + $urandom % 7;
      if (r < 75) begin
        f3 = $urandom % 7;
      end else begin
        f3 = $urandom % 4;
      end
      // aligned to the access size
      off = ($urandom % 32) * 8 + (($urandom % (8 >> f3[1:0])) << f3[1:0]);
      if (r < 20) begin
        add_inst(K_ADD, rd, rs1, rs2, 0, 0);
      end else if (r < 40) begin
        add_inst(K_ADDI, rd, rs1, 0, 0, $urandom % 4096);
      end else if (r < 50) begin
        add_inst(K_LUI, rd, 0, 0, 0, $urandom % (1 << 20));
      end else if (r < 75) begin
        add_inst(K_LOAD, rd, 7, 0, f3, off);
      end else begin
        add_inst(K_STORE, 0, 7, rs2, f3, off);
      end
    end
    for (int i = 1; i < 8; i++) begin
      add_inst(K_STORE, 0, 7, i, 3, DUMP_OFF + 8 * (i - 1));
    end
    add_inst(K_EBREAK, 0, 0, 0, 0, 0);
  endtask

  task automatic build_images;
    npc_pkg::addr_t a;
    int             idx;
    for (int i = 0; i < MEM_DW; i++) begin
      model_mem[i] = fill_word(npc_pkg::addr_t'(i * 8));
    end
    for (int k = 0; k < N_INSTS; k++) begin
      a   = RESET_PC + npc_pkg::addr_t'(4 * k);
      idx = int'(a[31:3]);
      if (a[2]) begin
        model_mem[idx][63:32] = word_a[k];
      end else begin
        model_mem[idx][31:0] = word_a[k];
      end
    end
    for (int i = 0; i < MEM_DW; i++) begin
      u_mem.mem[i] = model_mem[i];
    end
  endtask

  // reference model that queues expected requests in bus order
  task automatic run_model;
    npc_pkg::addr_t    pc;
    npc_pkg::addr_t    addr;
    npc_pkg::dword_t   raw;
    npc_pkg::dword_t   lanes;
    npc_pkg::mem_req_t req;
    logic [7:0]        mask;
    int                idx;
    int                lane;
    pc = RESET_PC;
    for (int r = 0; r < 8; r++) begin
      model_regs[r] = '0;
    end
    for (int i = 0; i < N_INSTS; i++) begin
      req      = '0;
      req.addr = pc;
      exp_kind.push_back(REQ_FETCH);
      exp_req.push_back(req);
      raw  = model_regs[rs1_a[i]] + {{52{imm_a[i][11]}}, imm_a[i][11:0]};
      addr = raw[31:0];
      idx  = int'(addr[13:3]);
      lane = int'(addr[2:0]);
      case (kind_a[i])
        K_ADD:  model_regs[rd_a[i]] = model_regs[rs1_a[i]] + model_regs[rs2_a[i]];
        K_ADDI: model_regs[rd_a[i]] = raw;
        K_LUI:  model_regs[rd_a[i]] = {{32{imm_a[i][19]}}, imm_a[i][19:0], 12'h000};
        K_LOAD: begin
          raw = model_mem[idx] >> (8 * lane);
          case (f3_a[i])
            0:       model_regs[rd_a[i]] = {{56{raw[7]}}, raw[7:0]};
            1:       model_regs[rd_a[i]] = {{48{raw[15]}}, raw[15:0]};
            2:       model_regs[rd_a[i]] = {{32{raw[31]}}, raw[31:0]};
            4:       model_regs[rd_a[i]] = {56'd0, raw[7:0]};
            5:       model_regs[rd_a[i]] = {48'd0, raw[15:0]};
            6:       model_regs[rd_a[i]] = {32'd0, raw[31:0]};
            default: model_regs[rd_a[i]] = raw;
          endcase
          req.addr = addr;
          exp_kind.push_back(REQ_LOAD);
          exp_req.push_back(req);
        end
        K_STORE: begin
          case (f3_a[i])
            0:       mask = 8'h01;
            1:       mask = 8'h03;
            2:       mask = 8'h0f;
            default: mask = 8'hff;
          endcase
          mask  = mask << lane;
          lanes = byte_lanes(mask);
          raw   = model_regs[rs2_a[i]] << (8 * lane);
          model_mem[idx] = (model_mem[idx] & ~lanes) | (raw & lanes);
          req.addr  = addr;
          req.wdata = raw & lanes;
          req.wmask = mask;
          req.write = 1'b1;
          exp_kind.push_back(REQ_STORE);
          exp_req.push_back(req);
        end
        default: ;
      endcase
      pc = pc + 32'd4;
    end
  endtask

  // pops the next expected request and ignores bytes outside the mask
  task automatic match_request(input npc_pkg::mem_req_t act);
    int                kind;
    npc_pkg::mem_req_t exp;
    npc_pkg::mem_req_t masked;
    if (exp_kind.size() == 0) begin
      $display("request to %h completed but none was expected", act.addr);
      proto_errs++;
      return;
    end
    kind = exp_kind.pop_front();
    exp  = exp_req.pop_front();
    if (kind == REQ_STORE) begin
      masked       = act;
      masked.wdata = act.wdata & byte_lanes(exp.wmask);
      check_req("mem_req_o", masked, exp);
    end else begin
      check_addr("mem_req_o.addr", act.addr, exp.addr);
      if (act.write !== 1'b0) begin
        $display("read at %h was issued as a write", exp.addr);
        proto_errs++;
      end
    end
  endtask

  // bus monitor samples on the falling edge
  always @(negedge clk) begin
    if (rst || low_cycles == 0) begin
      if (mem_valid !== 1'b0 || halt !== 1'b0) begin
        $display("mem_valid_o or halt_o was not low during or right after reset");
        proto_errs++;
      end
    end
    if (!rst) begin
      low_cycles++;
      if (prev_valid && !prev_ready && mem_valid) begin
        check_req("mem_req_o", mem_req, prev_req);
      end
      if (mem_valid && mem_ready) begin
        period_done++;
      end
      if (prev_valid && !mem_valid) begin
        if (period_done != 1) begin
          $display("valid period ended with %0d completed accesses", period_done);
          proto_errs++;
        end
        period_done = 0;
      end
      if (cmpl) begin
        match_request(cmpl_req);
      end
      if (halt_seen && (mem_valid || !halt)) begin
        $display("request seen or halt_o dropped after the core halted");
        proto_errs++;
      end
    end
    prev_valid = mem_valid;
    prev_ready = mem_ready;
    prev_req   = mem_req;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("timeout: core did not finish within %0d cycles", TIMEOUT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    void'($urandom(SEED));
    gen_program();
    build_images();
    run_model();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    while (halt !== 1'b1) begin
      @(negedge clk);
    end
    halt_seen = 1'b1;
    // quiet bus expected while parked
    repeat (50) @(negedge clk);
    @(posedge clk);
    for (int i = 1; i < 8; i++) begin
      check_dword($sformatf("dump x%0d", i), u_mem.mem[DUMP_IDX + i - 1], model_regs[i]);
    end
    for (int i = 0; i < CHECK_DW; i++) begin
      check_dword($sformatf("mem[%h]", DATA_BASE + npc_pkg::addr_t'(8 * i)),
                  u_mem.mem[DATA_IDX + i], model_mem[DATA_IDX + i]);
    end
    if (exp_kind.size() != 0) begin
      $display("%0d expected requests never completed", exp_kind.size());
      proto_errs++;
    end
    $display("summary: address %0d, request %0d, data %0d, protocol %0d errors",
             addr_errs, req_errs, data_errs, proto_errs);
    if (addr_errs + req_errs + data_errs + proto_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- tb/npc_tb_mem.sv
`timescale 1ns/1ps

module npc_tb_mem #(
  parameter int MEM_DW = 2048
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              mem_valid_i,
  input  npc_pkg::mem_req_t mem_req_i,
  output logic              mem_ready_o,
  output npc_pkg::dword_t   mem_rdata_o,
  output logic              cmpl_o,
  output npc_pkg::mem_req_t cmpl_req_o
);

  localparam int IDX_W = $clog2(MEM_DW);

  // doubleword storage, image loaded by the testbench top
  npc_pkg::dword_t   mem [MEM_DW];

  logic              ready_q    = 1'b0;
  npc_pkg::dword_t   rdata_q    = '0;
  logic              cmpl_q     = 1'b0;
  npc_pkg::mem_req_t cmpl_req_q = '0;
  logic              armed_q    = 1'b0;
  logic [1:0]        delay_q    = '0;
  logic [1:0]        pick;
  logic [IDX_W-1:0]  idx;
  npc_pkg::dword_t   lanes;

  always @(posedge clk) begin
    idx = mem_req_i.addr[IDX_W+2:3];
    if (rst) begin
      ready_q <= 1'b0;
      armed_q <= 1'b0;
      delay_q <= '0;
      cmpl_q  <= 1'b0;
    end else begin
      cmpl_q <= 1'b0;
      if (ready_q) begin
        // core takes the access at this edge
        ready_q    <= 1'b0;
        cmpl_q     <= 1'b1;
        cmpl_req_q <= mem_req_i;
        if (mem_req_i.write) begin
          for (int b = 0; b < 8; b++) begin
            lanes[8*b +: 8] = {8{mem_req_i.wmask[b]}};
          end
          mem[idx] = (mem[idx] & ~lanes) | (mem_req_i.wdata & lanes);
        end
      end else if (mem_valid_i) begin
        if (!armed_q) begin
          // 0 to 3 idle cycles before ready
          pick = 2'($urandom % 4);
          if (pick == 2'd0) begin
            ready_q <= 1'b1;
            rdata_q <= mem[idx];
          end else begin
            armed_q <= 1'b1;
            delay_q <= pick - 2'd1;
          end
        end else if (delay_q == 2'd0) begin
          armed_q <= 1'b0;
          ready_q <= 1'b1;
          rdata_q <= mem[idx];
        end else begin
          delay_q <= delay_q - 2'd1;
        end
      end
    end
  end

  assign mem_ready_o = ready_q;
  assign mem_rdata_o = rdata_q;
  assign cmpl_o      = cmpl_q;
  assign cmpl_req_o  = cmpl_req_q;

endmodule
